// File: verilog/afifo_cfg.svh
// async FIFO configuration
// depth, data width and almost-flag thresholds shared by every block

`ifndef AFIFO_CFG_SVH
`define AFIFO_CFG_SVH

// storage geometry, depth must be a power of two
`define AFIFO_DEPTH     16
`define AFIFO_DATA_W    8
`define AFIFO_AW        4

// almost_full when free entries seen by the writer drop below this
`define AFIFO_AF_THRESH 2

// almost_empty when entries seen by the reader drop below this
`define AFIFO_AE_THRESH 2

`endif

// File: verilog/afifo_ptr_pkg.sv
// async FIFO pointer package
// pointer and address types plus binary/gray conversion

`default_nettype none
`include "afifo_cfg.svh"

package afifo_ptr_pkg;

  typedef logic [`AFIFO_AW:0]   ptr_t;   // msb is the wrap flag
  typedef logic [`AFIFO_AW-1:0] addr_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  // each binary bit is the xor of all gray bits at or above it
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[`AFIFO_AW] = gray[`AFIFO_AW];
    for (int i = `AFIFO_AW - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

// File: verilog/afifo_rd_pkg.sv
// async FIFO read side package
// read state encoding and the data word type

`default_nettype none
`include "afifo_cfg.svh"

package afifo_rd_pkg;

  typedef logic [`AFIFO_DATA_W-1:0] data_t;

  // occupancy as seen by the read domain
  typedef enum logic [1:0] {
    RD_EMPTY = 2'd0,  // nothing stored
    RD_LOW   = 2'd1,  // below the almost-empty threshold
    RD_AVAIL = 2'd2
  } rd_state_e;

endpackage

`default_nettype wire

// File: verilog/afifo_wr_ctl.sv
// async FIFO write controller
// owns the write pointer, syncs the read pointer into wclk and
// registers full / almost_full from the next-state pointers

`timescale 1ns/1ns
`default_nettype none
`include "afifo_cfg.svh"

module afifo_wr_ctl (
  input  wire                        wclk,
  input  wire                        fflush,
  input  wire                        wen,
  input  wire afifo_ptr_pkg::ptr_t   rgray,
  output logic                       mem_we,
  output afifo_ptr_pkg::addr_t       mem_waddr,
  output afifo_ptr_pkg::ptr_t        wgray,
  output logic                       full,
  output logic                       almost_full
);

  afifo_ptr_pkg::ptr_t wbin;        // binary write pointer
  afifo_ptr_pkg::ptr_t wbin_next;
  afifo_ptr_pkg::ptr_t wgray_next;
  afifo_ptr_pkg::ptr_t rgray_s1;    // first sync stage
  afifo_ptr_pkg::ptr_t rgray_s2;    // second sync stage
  afifo_ptr_pkg::ptr_t rbin_s;      // synced read pointer in binary
  afifo_ptr_pkg::ptr_t used_next;
  afifo_ptr_pkg::ptr_t free_next;
  afifo_ptr_pkg::ptr_t full_match;
  logic                full_next;
  logic                afull_next;

  // a write while full is dropped here
  assign mem_we    = wen & ~full;
  assign mem_waddr = wbin[`AFIFO_AW-1:0];

  assign wbin_next  = mem_we ? wbin + 1'b1 : wbin;
  assign wgray_next = afifo_ptr_pkg::bin2gray(wbin_next);

  // read pointer arrives late, so the used count can only be too high
  always_ff @(posedge wclk or posedge fflush) begin
    if (fflush) begin
      rgray_s1 <= '0;
      rgray_s2 <= '0;
    end else begin
      rgray_s1 <= rgray;
      rgray_s2 <= rgray_s1;
    end
  end

  assign rbin_s = afifo_ptr_pkg::gray2bin(rgray_s2);

  // full in gray: top two bits inverted, the rest equal
  assign full_match = {~rgray_s2[`AFIFO_AW:`AFIFO_AW-1], rgray_s2[`AFIFO_AW-2:0]};
  assign full_next  = (wgray_next == full_match);

  // modulo arithmetic on the wide pointers handles the wrap
  assign used_next  = wbin_next - rbin_s;
  assign free_next  = afifo_ptr_pkg::ptr_t'(`AFIFO_DEPTH) - used_next;
  assign afull_next = (free_next < afifo_ptr_pkg::ptr_t'(`AFIFO_AF_THRESH));

  always_ff @(posedge wclk or posedge fflush) begin
    if (fflush) begin
      wbin  <= '0;
      wgray <= '0;
    end else begin
      wbin  <= wbin_next;
      wgray <= wgray_next;  // only gray crosses to rclk
    end
  end

  // flags move on the same edge as the write that causes them
  always_ff @(posedge wclk or posedge fflush) begin
    if (fflush) begin
      full        <= 1'b0;
      almost_full <= 1'b0;
    end else begin
      full        <= full_next;
      almost_full <= afull_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/afifo_rd_ctl.sv
// async FIFO read controller
// owns the read pointer, syncs the write pointer into rclk and keeps
// an occupancy state from which empty / almost_empty are decoded

`timescale 1ns/1ns
`default_nettype none
`include "afifo_cfg.svh"

module afifo_rd_ctl (
  input  wire                        rclk,
  input  wire                        fflush,
  input  wire                        ren,
  input  wire afifo_ptr_pkg::ptr_t   wgray,
  output logic                       mem_re,
  output afifo_ptr_pkg::addr_t       mem_raddr,
  output afifo_ptr_pkg::ptr_t        rgray,
  output logic                       empty,
  output logic                       almost_empty
);

  afifo_ptr_pkg::ptr_t     rbin;      // binary read pointer
  afifo_ptr_pkg::ptr_t     rbin_next;
  afifo_ptr_pkg::ptr_t     rgray_next;
  afifo_ptr_pkg::ptr_t     wgray_s1;  // first sync stage
  afifo_ptr_pkg::ptr_t     wgray_s2;  // second sync stage
  afifo_ptr_pkg::ptr_t     wbin_s;
  afifo_ptr_pkg::ptr_t     occ_next;  // words left after this edge
  afifo_rd_pkg::rd_state_e rd_state;
  afifo_rd_pkg::rd_state_e rd_state_next;

  // pop while empty is ignored
  assign mem_re    = ren & ~empty;
  assign mem_raddr = rbin[`AFIFO_AW-1:0];

  assign rbin_next  = mem_re ? rbin + 1'b1 : rbin;
  assign rgray_next = afifo_ptr_pkg::bin2gray(rbin_next);

  always_ff @(posedge rclk or posedge fflush) begin
    if (fflush) begin
      wgray_s1 <= '0;
      wgray_s2 <= '0;
    end else begin
      wgray_s1 <= wgray;
      wgray_s2 <= wgray_s1;
    end
  end

  // synced write pointer lags, so occupancy is never overstated
  assign wbin_s   = afifo_ptr_pkg::gray2bin(wgray_s2);
  assign occ_next = wbin_s - rbin_next;

  always_comb begin
    if (occ_next == '0) begin
      rd_state_next = afifo_rd_pkg::RD_EMPTY;
    end else if (occ_next < afifo_ptr_pkg::ptr_t'(`AFIFO_AE_THRESH)) begin
      rd_state_next = afifo_rd_pkg::RD_LOW;
    end else begin
      rd_state_next = afifo_rd_pkg::RD_AVAIL;
    end
  end

  always_ff @(posedge rclk or posedge fflush) begin
    if (fflush) begin
      rbin  <= '0;
      rgray <= '0;
    end else begin
      rbin  <= rbin_next;
      rgray <= rgray_next;
    end
  end

  // state register, updated at the pop edge
  always_ff @(posedge rclk or posedge fflush) begin
    if (fflush) begin
      rd_state <= afifo_rd_pkg::RD_EMPTY;
    end else begin
      rd_state <= rd_state_next;
    end
  end

  // flags straight from the state flops
  assign empty        = (rd_state == afifo_rd_pkg::RD_EMPTY);
  assign almost_empty = (rd_state != afifo_rd_pkg::RD_AVAIL);

endmodule

`default_nettype wire

// File: verilog/afifo_mem.sv
// async FIFO storage array
// dual port, write on wclk, registered read on rclk

`timescale 1ns/1ns
`default_nettype none
`include "afifo_cfg.svh"

module afifo_mem (
  input  wire                        wclk,
  input  wire                        rclk,
  input  wire                        fflush,
  input  wire                        we,
  input  wire afifo_ptr_pkg::addr_t  waddr,
  input  wire afifo_rd_pkg::data_t   wdata,
  input  wire                        re,
  input  wire afifo_ptr_pkg::addr_t  raddr,
  output afifo_rd_pkg::data_t        rdata
);

  afifo_rd_pkg::data_t mem [`AFIFO_DEPTH];

  always_ff @(posedge wclk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // rdata holds the last popped word until the next pop
  always_ff @(posedge rclk or posedge fflush) begin
    if (fflush) begin
      rdata <= '0;
    end else if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// File: verilog/afifo_top.sv
// async FIFO top level
// byte FIFO from wclk to rclk with gray pointers crossing domains

`timescale 1ns/1ns
`default_nettype none

module afifo_top (
  input  wire                       wclk,
  input  wire                       rclk,
  input  wire                       fflush,
  input  wire                       wen,
  input  wire afifo_rd_pkg::data_t  wdata,
  input  wire                       ren,
  output logic                      full,
  output logic                      almost_full,
  output afifo_rd_pkg::data_t       rdata,
  output logic                      empty,
  output logic                      almost_empty
);

  wire                       mem_we;
  wire afifo_ptr_pkg::addr_t mem_waddr;
  wire                       mem_re;
  wire afifo_ptr_pkg::addr_t mem_raddr;
  wire afifo_ptr_pkg::ptr_t  wgray;     // wclk domain, synced in rd_ctl
  wire afifo_ptr_pkg::ptr_t  rgray;     // rclk domain, synced in wr_ctl

  afifo_wr_ctl u_wr_ctl (
    .wclk        (wclk),
    .fflush      (fflush),
    .wen         (wen),
    .rgray       (rgray),
    .mem_we      (mem_we),
    .mem_waddr   (mem_waddr),
    .wgray       (wgray),
    .full        (full),
    .almost_full (almost_full)
  );

  afifo_rd_ctl u_rd_ctl (
    .rclk         (rclk),
    .fflush       (fflush),
    .ren          (ren),
    .wgray        (wgray),
    .mem_re       (mem_re),
    .mem_raddr    (mem_raddr),
    .rgray        (rgray),
    .empty        (empty),
    .almost_empty (almost_empty)
  );

  afifo_mem u_mem (
    .wclk   (wclk),
    .rclk   (rclk),
    .fflush (fflush),
    .we     (mem_we),
    .waddr  (mem_waddr),
    .wdata  (wdata),
    .re     (mem_re),
    .raddr  (mem_raddr),
    .rdata  (rdata)
  );

endmodule

`default_nettype wire

// File: tests/afifo_assertions.sv
// async FIFO checker bound to afifo_top
// reset values, full and empty edges, and rdata hold while empty

`timescale 1ns/1ns
`default_nettype none
`include "afifo_cfg.svh"

module afifo_assertions (
  input wire                      wclk,
  input wire                      rclk,
  input wire                      fflush,
  input wire                      wen,
  input wire                      ren,
  input wire                      full,
  input wire                      almost_full,
  input wire                      empty,
  input wire                      almost_empty,
  input wire afifo_rd_pkg::data_t rdata
);

  int unsigned fail_count = 0;
  int unsigned wr_cnt;  // accepted writes in the wclk domain
  int unsigned rd_cnt;  // accepted pops in the rclk domain
  int unsigned occ;

  always_ff @(posedge wclk or posedge fflush) begin
    if (fflush) begin
      wr_cnt <= 0;
    end else if (wen && !full) begin
      wr_cnt <= wr_cnt + 1;
    end
  end

  always_ff @(posedge rclk or posedge fflush) begin
    if (fflush) begin
      rd_cnt <= 0;
    end else if (ren && !empty) begin
      rd_cnt <= rd_cnt + 1;
    end
  end

  assign occ = wr_cnt - rd_cnt;  // true number of stored words

  reset_values: assert property (@(posedge rclk) $fell(fflush) |->
      empty && almost_empty && !full && !almost_full && rdata == '0)
    else begin
      fail_count++;
      $error("flags or rdata wrong after reset");
    end

  // the write that stores the last free entry raises full at its own edge
  full_on_last_write: assert property (@(posedge wclk) disable iff (fflush)
      (wen && !full && occ == `AFIFO_DEPTH - 1) |=> full)
    else begin
      fail_count++;
      $error("full did not rise on the last write");
    end

  empty_on_last_pop: assert property (@(posedge rclk) disable iff (fflush)
      (ren && !empty && occ == 1) |=> empty)
    else begin
      fail_count++;
      $error("empty did not rise on the last pop");
    end

  rdata_hold_when_empty: assert property (@(posedge rclk) disable iff (fflush)
      empty |=> $stable(rdata))
    else begin
      fail_count++;
      $error("rdata changed on a read while empty");
    end

endmodule

bind afifo_top afifo_assertions u_assert (
  .wclk         (wclk),
  .rclk         (rclk),
  .fflush       (fflush),
  .wen          (wen),
  .ren          (ren),
  .full         (full),
  .almost_full  (almost_full),
  .empty        (empty),
  .almost_empty (almost_empty),
  .rdata        (rdata)
);

`default_nettype wire

// File: tests/afifo_tb.sv
// async FIFO testbench
// LFSR fill/drain traffic across wclk and rclk, checked against a reference queue

`timescale 1ns/1ns
`default_nettype none
`include "afifo_cfg.svh"

module afifo_tb;

  localparam int MIX_CYC      = 300;
  localparam int TIMEOUT_CYC  = 4000;  // covers four phases with a wide margin
  localparam int PH_IDLE      = 0;
  localparam int PH_FILL      = 1;
  localparam int PH_DRAIN     = 2;
  localparam int PH_MIX_FILL  = 3;
  localparam int PH_MIX_DRAIN = 4;

  logic                wclk;
  logic                rclk;
  logic                fflush;
  logic                wen;
  afifo_rd_pkg::data_t wdata;
  logic                ren;
  logic                full;
  logic                almost_full;
  afifo_rd_pkg::data_t rdata;
  logic                empty;
  logic                almost_empty;

  afifo_rd_pkg::data_t ref_q [$];
  afifo_rd_pkg::data_t exp_word = '0;
  logic [15:0]         lfsr = 16'd9;
  int                  phase = PH_IDLE;
  int                  errors = 0;
  int                  cycles = 0;
  logic                running = 1'b0;
  logic                wr_pend = 1'b0;  // write taken at the coming wclk edge
  logic                rd_pend = 1'b0;  // pop taken at the coming rclk edge
  logic                w_bit;
  logic                r_bit;

  afifo_top afifo_top_i (
    .wclk         (wclk),
    .rclk         (rclk),
    .fflush       (fflush),
    .wen          (wen),
    .wdata        (wdata),
    .ren          (ren),
    .full         (full),
    .almost_full  (almost_full),
    .rdata        (rdata),
    .empty        (empty),
    .almost_empty (almost_empty)
  );

  initial begin
    rclk = 1'b0;
    forever #50 rclk = ~rclk;
  end

  // offset so that no wclk edge lines up with an rclk edge
  initial begin
    wclk = 1'b0;
    #13;
    forever #35 wclk = ~wclk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // or of two bits leans toward 1 and the and of two toward 0
  task automatic draw_bit(input logic lean_high, output logic b);
    logic b0;
    logic b1;
    lfsr = lfsr_step(lfsr);
    b0   = lfsr[0];
    lfsr = lfsr_step(lfsr);
    b1   = lfsr[0];
    b    = lean_high ? (b0 | b1) : (b0 & b1);
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    errors++;
    $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("error: %s", what);
  endtask

  // write side checks run before the new stimulus
  always @(negedge wclk) begin
    if (running) begin
      assert ((`AFIFO_DEPTH - ref_q.size()) >= `AFIFO_AF_THRESH || almost_full)
        else report_mismatch("almost_full_bound", 1, almost_full);
      if (wr_pend) begin
        wdata = wdata + 1'b1;  // advance only once the word was taken
      end
      case (phase)
        PH_FILL, PH_MIX_FILL: draw_bit(1'b1, w_bit);
        PH_MIX_DRAIN:         draw_bit(1'b0, w_bit);
        default:              w_bit = 1'b0;
      endcase
      wen     = w_bit;
      wr_pend = wen && !full;
    end
  end

  always @(posedge wclk) begin
    if (wr_pend) begin
      assert (ref_q.size() < `AFIFO_DEPTH)
        else report_problem("write accepted while every entry was in use");
      ref_q.push_back(wdata);
    end
  end

  always @(negedge rclk) begin
    if (running) begin
      if (rd_pend) begin
        assert (rdata == exp_word) else report_mismatch("data_order", exp_word, rdata);
      end
      assert (ref_q.size() >= `AFIFO_AE_THRESH || almost_empty)
        else report_mismatch("almost_empty_bound", 1, almost_empty);
      assert (!(full && empty)) else report_problem("full and empty are high together");
      case (phase)
        PH_DRAIN, PH_MIX_DRAIN: draw_bit(1'b1, r_bit);
        PH_MIX_FILL:            draw_bit(1'b0, r_bit);
        default:                r_bit = 1'b0;
      endcase
      ren     = r_bit;
      rd_pend = ren && !empty;
    end
  end

  always @(posedge rclk) begin
    if (rd_pend) begin
      if (ref_q.size() == 0) begin
        report_problem("pop accepted with nothing left in the reference queue");
      end else begin
        exp_word = ref_q.pop_front();
      end
    end
  end

  always @(posedge rclk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("error: run did not finish within %0d rclk cycles", TIMEOUT_CYC);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    fflush = 1'b1;
    wen    = 1'b0;
    ren    = 1'b0;
    wdata  = '0;
    repeat (2) @(posedge rclk);
    @(negedge rclk);
    fflush = 1'b0;
    @(posedge rclk);
    running = 1'b1;
    phase   = PH_FILL;  // reads held off
    wait (full);
    repeat (8) @(negedge wclk);  // writes against full
    assert (ref_q.size() == `AFIFO_DEPTH)
      else report_mismatch("fill_level", `AFIFO_DEPTH, ref_q.size());
    @(posedge rclk);
    phase = PH_DRAIN;
    while (!(empty && ref_q.size() == 0)) @(negedge rclk);
    repeat (8) @(negedge rclk);  // reads against empty
    @(posedge rclk);
    phase = PH_MIX_FILL;
    repeat (MIX_CYC) @(posedge rclk);
    phase = PH_MIX_DRAIN;
    repeat (MIX_CYC) @(posedge rclk);
    phase = PH_DRAIN;  // read back what is left
    @(negedge rclk);
    while (!(empty && ref_q.size() == 0)) @(negedge rclk);
    @(posedge rclk);
    phase = PH_IDLE;
    repeat (4) @(negedge rclk);
    $display("errors: %0d testbench checks, %0d bound assertions",
             errors, afifo_top_i.u_assert.fail_count);
    if (errors == 0 && afifo_top_i.u_assert.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/afifo_ptr_pkg.sv
verilog/afifo_rd_pkg.sv
verilog/afifo_wr_ctl.sv
verilog/afifo_rd_ctl.sv
verilog/afifo_mem.sv
verilog/afifo_top.sv
tests/afifo_assertions.sv
tests/afifo_tb.sv
